//--- common/flash_boot_pkg.sv
/*
 * flash_boot shared definitions
 * widths, the SPI read opcode and the FSM and register encodings
 */

package flash_boot_pkg;

    // flash byte address, one 24-bit SPI address phase
    localparam int FLASH_ADDR_W = 24;

    // data word carried from flash to RAM and CPU
    localparam int WORD_W = 32;

    // CPU word address into the user area of flash
    localparam int CPU_ADDR_W = 18;

    // plain serial read, no dummy cycles
    localparam logic [7:0] FLASH_CMD_READ = 8'h03;

    // configuration register select
    typedef enum logic [1:0] {
        CFG_LOAD_BASE  = 2'd0,
        CFG_LOAD_WORDS = 2'd1,
        CFG_WRITE_BASE = 2'd2,
        CFG_START      = 2'd3
    } cfg_reg_e;

    // flash_dma arbitration states
    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_LOAD,
        DMA_WRITE,
        DMA_CPU_READ,
        DMA_CPU_DONE
    } dma_state_e;

    // SPI reader states
    typedef enum logic [2:0] {
        SPI_IDLE,
        SPI_CMD,
        SPI_ADDR,
        SPI_DATA,
        SPI_HOLD
    } spi_state_e;

endpackage

//--- design/boot_config.sv
/*
 * boot_config: copy source, length and destination registers
 * plus the start strobe, fired once after reset when IPL is on
 */

`timescale 1ns/1ps

module boot_config
    import flash_boot_pkg::*;
#(
    parameter bit                      ENABLE_IPL = 1'b1,
    parameter int                      RAM_WORDS  = 256,
    parameter logic [FLASH_ADDR_W-1:0] LOAD_BASE  = 24'h10_0000,
    parameter logic [FLASH_ADDR_W-1:0] LOAD_WORDS = 24'd16,
    parameter logic [WORD_W-1:0]       WRITE_BASE = 32'd0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cfg_write,
    input  cfg_reg_e                cfg_reg,
    input  logic [WORD_W-1:0]       cfg_wdata,
    input  logic                    dma_busy,
    output logic [FLASH_ADDR_W-1:0] load_base,
    output logic [FLASH_ADDR_W-1:0] load_words,
    output logic [WORD_W-1:0]       write_base,
    output logic                    dma_start
);

    // destination wraps inside the RAM, depth is a power of two
    localparam logic [WORD_W-1:0] RAM_MASK = WORD_W'(RAM_WORDS - 1);

    logic ipl_pending;

    // automatic start in the first cycle after reset, or a start write
    // that is refused while a copy is running
    assign dma_start = ipl_pending ||
                       (cfg_write && cfg_reg == CFG_START && !dma_busy);

    always_ff @(posedge clk) begin
        if (reset) begin
            ipl_pending <= ENABLE_IPL;
            load_base   <= LOAD_BASE;
            load_words  <= LOAD_WORDS;
            write_base  <= WRITE_BASE & RAM_MASK;
        end else begin
            ipl_pending <= 1'b0;
            if (cfg_write) begin
                case (cfg_reg)
                    CFG_LOAD_BASE:  load_base  <= cfg_wdata[FLASH_ADDR_W-1:0];
                    CFG_LOAD_WORDS: load_words <= cfg_wdata[FLASH_ADDR_W-1:0];
                    CFG_WRITE_BASE: write_base <= cfg_wdata & RAM_MASK;
                    // start has no storage
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- design/boot_ram.sv
/*
 * boot_ram: word-addressed boot memory
 * byte-lane write port for the DMA, registered read port
 */

`timescale 1ns/1ps

module boot_ram
    import flash_boot_pkg::*;
#(
    parameter int RAM_WORDS = 256
) (
    input  logic                         clk,
    input  logic [3:0]                   wstrb,
    input  logic [WORD_W-1:0]            write_address,
    input  logic [WORD_W-1:0]            write_data,
    input  logic                         ram_read_en,
    input  logic [$clog2(RAM_WORDS)-1:0] ram_read_address,
    output logic [WORD_W-1:0]            ram_read_data
);

    localparam int RAM_AW = $clog2(RAM_WORDS);

    logic [WORD_W-1:0] mem [RAM_WORDS];

    // upper address bits drop off, so writes wrap around the RAM
    logic [RAM_AW-1:0] write_index;

    assign write_index = write_address[RAM_AW-1:0];

    always_ff @(posedge clk) begin
        // each lane follows its own strobe bit
        for (int lane = 0; lane < 4; lane++) begin
            if (wstrb[lane]) begin
                mem[write_index][lane*8 +: 8] <= write_data[lane*8 +: 8];
            end
        end
    end

    // data is valid one cycle after the enable
    always_ff @(posedge clk) begin
        if (ram_read_en) begin
            ram_read_data <= mem[ram_read_address];
        end
    end

endmodule

//--- design/flash_boot_top.sv
/*
 * flash_boot_top: boot loader and flash read path
 * config block, DMA arbiter, SPI flash reader and boot RAM
 */

`timescale 1ns/1ps

module flash_boot_top
    import flash_boot_pkg::*;
#(
    parameter bit                      ENABLE_IPL = 1'b1,
    parameter logic [FLASH_ADDR_W-1:0] USER_BASE  = 24'h10_0000,
    parameter int                      RAM_WORDS  = 256,
    parameter logic [FLASH_ADDR_W-1:0] LOAD_BASE  = 24'h10_0000,
    parameter logic [FLASH_ADDR_W-1:0] LOAD_WORDS = 24'd16,
    parameter logic [WORD_W-1:0]       WRITE_BASE = 32'd0
) (
    input  logic                         clk,
    input  logic                         reset,

    // CPU read port
    input  logic                         read_en,
    input  logic [CPU_ADDR_W-1:0]        read_address,
    output logic [WORD_W-1:0]            read_data,
    output logic                         read_ready,

    // configuration port
    input  logic                         cfg_write,
    input  cfg_reg_e                     cfg_reg,
    input  logic [WORD_W-1:0]            cfg_wdata,

    // RAM read port
    input  logic                         ram_read_en,
    input  logic [$clog2(RAM_WORDS)-1:0] ram_read_address,
    output logic [WORD_W-1:0]            ram_read_data,

    output logic                         dma_busy,

    // SPI flash pins
    output logic                         flash_sck,
    output logic                         flash_csn,
    output logic                         flash_mosi,
    input  logic                         flash_miso
);

    // copy setup
    logic [FLASH_ADDR_W-1:0] load_base;
    logic [FLASH_ADDR_W-1:0] load_words;
    logic [WORD_W-1:0]       write_base;
    logic                    dma_start;

    // reader request
    logic                    flash_valid;
    logic [FLASH_ADDR_W-1:0] flash_address;
    logic                    flash_continue;
    logic                    flash_ready;
    logic [WORD_W-1:0]       flash_rdata;

    // RAM write port
    logic [3:0]              wstrb;
    logic [WORD_W-1:0]       write_address;
    logic [WORD_W-1:0]       write_data;

    boot_config #(
        .ENABLE_IPL (ENABLE_IPL),
        .RAM_WORDS  (RAM_WORDS),
        .LOAD_BASE  (LOAD_BASE),
        .LOAD_WORDS (LOAD_WORDS),
        .WRITE_BASE (WRITE_BASE)
    ) i_boot_config (
        .clk        (clk),
        .reset      (reset),
        .cfg_write  (cfg_write),
        .cfg_reg    (cfg_reg),
        .cfg_wdata  (cfg_wdata),
        .dma_busy   (dma_busy),
        .load_base  (load_base),
        .load_words (load_words),
        .write_base (write_base),
        .dma_start  (dma_start)
    );

    flash_dma #(
        .USER_BASE (USER_BASE)
    ) i_flash_dma (
        .clk            (clk),
        .reset          (reset),
        .load_base      (load_base),
        .load_words     (load_words),
        .write_base     (write_base),
        .dma_start      (dma_start),
        .dma_busy       (dma_busy),
        .read_en        (read_en),
        .read_address   (read_address),
        .read_data      (read_data),
        .read_ready     (read_ready),
        .flash_valid    (flash_valid),
        .flash_address  (flash_address),
        .flash_continue (flash_continue),
        .flash_ready    (flash_ready),
        .flash_rdata    (flash_rdata),
        .wstrb          (wstrb),
        .write_address  (write_address),
        .write_data     (write_data)
    );

    spi_flash_reader i_spi_flash_reader (
        .clk            (clk),
        .reset          (reset),
        .flash_valid    (flash_valid),
        .flash_address  (flash_address),
        .flash_continue (flash_continue),
        .flash_ready    (flash_ready),
        .flash_rdata    (flash_rdata),
        .flash_sck      (flash_sck),
        .flash_csn      (flash_csn),
        .flash_mosi     (flash_mosi),
        .flash_miso     (flash_miso)
    );

    boot_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_boot_ram (
        .clk              (clk),
        .wstrb            (wstrb),
        .write_address    (write_address),
        .write_data       (write_data),
        .ram_read_en      (ram_read_en),
        .ram_read_address (ram_read_address),
        .ram_read_data    (ram_read_data)
    );

endmodule

//--- flash_boot.f
common/flash_boot_pkg.sv
design/boot_config.sv
design/boot_ram.sv
flash_dma/spi_flash_reader.sv
flash_dma/flash_dma.sv
design/flash_boot_top.sv
verification/tb_clock_gen.sv
verification/spi_flash_model.sv
verification/tb_flash_boot.sv

//--- flash_dma/flash_dma.sv
/*
 * flash_dma: shares the flash reader between the boot copy and CPU reads
 * the copy has priority and writes each word into the boot RAM
 */

`timescale 1ns/1ps

module flash_dma
    import flash_boot_pkg::*;
#(
    parameter logic [FLASH_ADDR_W-1:0] USER_BASE = 24'h10_0000
) (
    input  logic                    clk,
    input  logic                    reset,

    // copy setup from boot_config
    input  logic [FLASH_ADDR_W-1:0] load_base,
    input  logic [FLASH_ADDR_W-1:0] load_words,
    input  logic [WORD_W-1:0]       write_base,
    input  logic                    dma_start,
    output logic                    dma_busy,

    // CPU random reads
    input  logic                    read_en,
    input  logic [CPU_ADDR_W-1:0]   read_address,
    output logic [WORD_W-1:0]       read_data,
    output logic                    read_ready,

    // flash reader request side
    output logic                    flash_valid,
    output logic [FLASH_ADDR_W-1:0] flash_address,
    output logic                    flash_continue,
    input  logic                    flash_ready,
    input  logic [WORD_W-1:0]       flash_rdata,

    // boot RAM write port
    output logic [3:0]              wstrb,
    output logic [WORD_W-1:0]       write_address,
    output logic [WORD_W-1:0]       write_data
);

    dma_state_e state;

    // copy setup, captured when the copy is accepted
    logic [FLASH_ADDR_W-1:0] copy_base;
    logic [FLASH_ADDR_W-1:0] words_total;
    logic [FLASH_ADDR_W-1:0] word_count;
    logic [FLASH_ADDR_W-1:0] word_count_next;
    logic [FLASH_ADDR_W-1:0] next_words;
    logic [FLASH_ADDR_W-1:0] cpu_address;
    logic                    copy_request;
    logic                    last_word;

    // a start seen during a CPU read is remembered through dma_busy
    assign copy_request    = dma_start || dma_busy;
    assign next_words      = dma_busy ? words_total : load_words;
    assign word_count_next = word_count + 1'b1;
    assign last_word       = (word_count_next == words_total);

    // the reader streams sequential words, so the copy only needs its base
    assign flash_valid    = (state == DMA_LOAD) || (state == DMA_CPU_READ);
    assign flash_continue = (state == DMA_LOAD);
    assign flash_address  = (state == DMA_LOAD) ? copy_base : cpu_address;

    // reader holds rdata until the next word arrives
    assign write_data = flash_rdata;
    assign read_data  = flash_rdata;

    // CPU_DONE lasts exactly one cycle, one cycle after flash_ready
    assign read_ready = (state == DMA_CPU_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DMA_IDLE;
            dma_busy <= 1'b0;
            wstrb    <= 4'b0000;
        end else begin
            wstrb <= 4'b0000;

            // busy rises one cycle after the start strobe in every state
            if (dma_start && !dma_busy) begin
                dma_busy <= 1'b1;
            end

            case (state)
                DMA_IDLE: begin
                    if (copy_request) begin
                        // zero length goes straight to the closing cycle
                        state <= (next_words == '0) ? DMA_WRITE : DMA_LOAD;
                    end else if (read_en) begin
                        state <= DMA_CPU_READ;
                    end
                end
                DMA_LOAD: begin
                    if (flash_ready) begin
                        wstrb <= 4'b1111;
                        if (last_word) begin
                            state <= DMA_WRITE;
                        end
                    end
                end
                DMA_WRITE: begin
                    // last word goes into RAM in this cycle
                    state    <= DMA_IDLE;
                    dma_busy <= 1'b0;
                end
                DMA_CPU_READ: begin
                    if (flash_ready) begin
                        state <= DMA_CPU_DONE;
                    end
                end
                DMA_CPU_DONE: begin
                    if (copy_request) begin
                        state <= (next_words == '0) ? DMA_WRITE : DMA_LOAD;
                    end else begin
                        state <= DMA_IDLE;
                    end
                end
                default: begin
                    state <= DMA_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // latch the copy setup when the start is accepted
        if (dma_start && !dma_busy) begin
            copy_base     <= load_base;
            words_total   <= load_words;
            word_count    <= '0;
            write_address <= write_base;
        end else begin
            if (state == DMA_LOAD && flash_ready) begin
                word_count <= word_count_next;
            end
            // post-increment after every RAM write
            if (wstrb == 4'b1111) begin
                write_address <= write_address + 1'b1;
            end
        end

        // CPU word address to flash byte address
        if (state == DMA_IDLE && !copy_request && read_en) begin
            cpu_address <= USER_BASE + {read_address, 2'b00};
        end
    end

endmodule

//--- flash_dma/spi_flash_reader.sv
/*
 * spi_flash_reader: SPI mode 0 master for the flash read command
 * returns 32-bit words, first byte received in the low byte,
 * and streams further words while the request continues
 */

`timescale 1ns/1ps

module spi_flash_reader
    import flash_boot_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,

    // request side
    input  logic                    flash_valid,
    input  logic [FLASH_ADDR_W-1:0] flash_address,
    input  logic                    flash_continue,
    output logic                    flash_ready,
    output logic [WORD_W-1:0]       flash_rdata,

    // SPI pins
    output logic                    flash_sck,
    output logic                    flash_csn,
    output logic                    flash_mosi,
    input  logic                    flash_miso
);

    spi_state_e state;

    // command and address go out together, MSB first
    logic [31:0] tx_shift;
    logic [31:0] rx_shift;
    logic [4:0]  bit_count;

    assign flash_mosi = tx_shift[31];

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= SPI_IDLE;
            flash_csn   <= 1'b1;
            flash_sck   <= 1'b0;
            flash_ready <= 1'b0;
        end else begin
            flash_ready <= 1'b0;

            case (state)
                SPI_IDLE: begin
                    flash_sck <= 1'b0;
                    if (flash_valid) begin
                        flash_csn <= 1'b0;
                        state     <= SPI_CMD;
                    end
                end
                SPI_CMD, SPI_ADDR: begin
                    // sck toggles every clk, so it runs at half rate
                    flash_sck <= !flash_sck;
                    if (flash_sck) begin
                        if (bit_count == 5'd7) begin
                            state <= SPI_ADDR;
                        end else if (bit_count == 5'd31) begin
                            state <= SPI_DATA;
                        end
                    end
                end
                SPI_DATA: begin
                    flash_sck <= !flash_sck;
                    // the falling edge after bit 31 closes the word
                    if (flash_sck && bit_count == 5'd31) begin
                        flash_ready <= 1'b1;
                        state       <= SPI_HOLD;
                    end
                end
                SPI_HOLD: begin
                    // decide in the cycle after the ready pulse, once the
                    // requester has had a chance to drop valid
                    if (!flash_ready) begin
                        if (flash_valid && flash_continue) begin
                            state <= SPI_DATA;
                        end else begin
                            flash_csn <= 1'b1;
                            state     <= SPI_IDLE;
                        end
                    end
                end
                default: begin
                    flash_csn <= 1'b1;
                    flash_sck <= 1'b0;
                    state     <= SPI_IDLE;
                end
            endcase
        end
    end

    // shift registers and bit counter
    always_ff @(posedge clk) begin
        if (state == SPI_IDLE && flash_valid) begin
            tx_shift  <= {FLASH_CMD_READ, flash_address};
            bit_count <= '0;
        end else if (state == SPI_HOLD) begin
            bit_count <= '0;
        end else if (state != SPI_IDLE) begin
            if (!flash_sck) begin
                // rising edge, flash output is stable
                rx_shift <= {rx_shift[30:0], flash_miso};
            end else begin
                // falling edge, present the next bit
                tx_shift  <= {tx_shift[30:0], 1'b0};
                bit_count <= bit_count + 1'b1;
            end
        end

        // byte swap so the first byte lands in bits 7:0
        if (state == SPI_DATA && flash_sck && bit_count == 5'd31) begin
            flash_rdata <= {rx_shift[7:0], rx_shift[15:8],
                            rx_shift[23:16], rx_shift[31:24]};
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the flash_boot testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_flash_boot \
    -f flash_boot.f \
    -o sim_flash_boot

./obj_dir/sim_flash_boot | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed, see sim.log"
    exit 1
fi

//--- verification/spi_flash_model.sv
/*
 * spi_flash_model: behavioral SPI NOR flash, read command only
 * byte at address a is (a[23:16] + a[15:8] + a[7:0]) xor a5
 */

`timescale 1ns/1ps

module spi_flash_model
    import flash_boot_pkg::*;
(
    input  logic flash_sck,
    input  logic flash_csn,
    input  logic flash_mosi,
    output logic flash_miso,
    output logic bad_command
);

    // command and address as received, MSB first
    logic [31:0]             header;
    int                      header_bits;
    logic [FLASH_ADDR_W-1:0] byte_address;
    logic [7:0]              out_byte;
    int                      out_bit;

    function automatic logic [7:0] content_byte(input logic [FLASH_ADDR_W-1:0] address);
        logic [7:0] sum;
        sum = address[23:16] + address[15:8] + address[7:0];
        return sum ^ 8'ha5;
    endfunction

    initial begin
        flash_miso  = 1'b0;
        bad_command = 1'b0;
        header_bits = 0;
        out_bit     = 0;
    end

    // every new select starts a fresh command
    always @(negedge flash_csn) begin
        header_bits = 0;
        out_bit     = 0;
    end

    // mode 0, mosi is sampled on the rising sck edge
    always @(posedge flash_sck) begin
        if (flash_csn === 1'b0 && header_bits < 32) begin
            header      = {header[30:0], flash_mosi};
            header_bits = header_bits + 1;
            if (header_bits == 32) begin
                byte_address = header[23:0];
                if (header[31:24] != FLASH_CMD_READ) begin
                    bad_command = 1'b1;
                end
            end
        end
    end

    // data shifts out on the falling edge, MSB first, address increments per byte
    always @(negedge flash_sck) begin
        if (flash_csn === 1'b0 && header_bits == 32) begin
            out_byte   = content_byte(byte_address);
            flash_miso <= out_byte[7 - out_bit];
            if (out_bit == 7) begin
                out_bit      = 0;
                byte_address = byte_address + 1'b1;
            end else begin
                out_bit = out_bit + 1;
            end
        end
    end

endmodule

//--- verification/tb_clock_gen.sv
/*
 * tb_clock_gen: free running testbench clock, 8 ns period
 */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

//--- verification/tb_flash_boot.sv
/*
 * tb_flash_boot: testbench for the flash boot loader
 * boot copy, CPU reads, reprogrammed copies, ignored requests while busy
 */

`timescale 1ns/1ps

module tb_flash_boot
    import flash_boot_pkg::*;
();

    localparam bit                      ENABLE_IPL   = 1'b1;
    localparam logic [FLASH_ADDR_W-1:0] USER_BASE    = 24'h10_0000;
    localparam int                      RAM_WORDS    = 256;
    localparam logic [FLASH_ADDR_W-1:0] LOAD_BASE    = 24'h00_2f40;
    localparam logic [FLASH_ADDR_W-1:0] LOAD_WORDS   = 24'd16;
    localparam logic [WORD_W-1:0]       WRITE_BASE   = 32'd12;
    localparam int                      RAM_AW       = $clog2(RAM_WORDS);
    localparam int                      COPY_TIMEOUT = 4000;
    localparam int                      READ_TIMEOUT = 400;

    logic                    clk;
    logic                    reset;
    logic                    read_en;
    logic [CPU_ADDR_W-1:0]   read_address;
    logic [WORD_W-1:0]       read_data;
    logic                    read_ready;
    logic                    cfg_write;
    cfg_reg_e                cfg_reg;
    logic [WORD_W-1:0]       cfg_wdata;
    logic                    ram_read_en;
    logic [RAM_AW-1:0]       ram_read_address;
    logic [WORD_W-1:0]       ram_read_data;
    logic                    dma_busy;
    logic                    flash_sck;
    logic                    flash_csn;
    logic                    flash_mosi;
    logic                    flash_miso;
    logic                    bad_command;

    // shadow of the boot RAM for the entries a copy has written
    logic [WORD_W-1:0]       ram_model [RAM_WORDS];
    bit                      ram_written [RAM_WORDS];
    // expected read_data for each pending CPU read
    logic [WORD_W-1:0]       read_expect [$];

    tb_clock_gen i_tb_clock_gen (.clk(clk));

    spi_flash_model i_spi_flash_model (
        .flash_sck   (flash_sck),
        .flash_csn   (flash_csn),
        .flash_mosi  (flash_mosi),
        .flash_miso  (flash_miso),
        .bad_command (bad_command)
    );

    flash_boot_top #(
        .ENABLE_IPL (ENABLE_IPL),
        .USER_BASE  (USER_BASE),
        .RAM_WORDS  (RAM_WORDS),
        .LOAD_BASE  (LOAD_BASE),
        .LOAD_WORDS (LOAD_WORDS),
        .WRITE_BASE (WRITE_BASE)
    ) i_flash_boot_top (
        .clk              (clk),
        .reset            (reset),
        .read_en          (read_en),
        .read_address     (read_address),
        .read_data        (read_data),
        .read_ready       (read_ready),
        .cfg_write        (cfg_write),
        .cfg_reg          (cfg_reg),
        .cfg_wdata        (cfg_wdata),
        .ram_read_en      (ram_read_en),
        .ram_read_address (ram_read_address),
        .ram_read_data    (ram_read_data),
        .dma_busy         (dma_busy),
        .flash_sck        (flash_sck),
        .flash_csn        (flash_csn),
        .flash_mosi       (flash_mosi),
        .flash_miso       (flash_miso)
    );

    // word starting at a byte address from the flash content rule with the low byte first
    function automatic logic [WORD_W-1:0] expected_word(input logic [FLASH_ADDR_W-1:0] base);
        logic [FLASH_ADDR_W-1:0] address;
        logic [7:0]              sum;
        logic [WORD_W-1:0]       word;
        for (int i = 0; i < 4; i++) begin
            address          = base + FLASH_ADDR_W'(i);
            sum              = address[23:16] + address[15:8] + address[7:0];
            word[i*8 +: 8]   = sum ^ 8'ha5;
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [WORD_W-1:0] actual,
                               input logic [WORD_W-1:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t ns %s actual=%h expected=%h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%0t ns: %s", $time, reason);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // advance to 1 ns after the next rising edge where inputs change and outputs are stable
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (dma_busy !== level) begin
            if (cycles == limit) begin
                abort_run($sformatf("dma_busy did not go to %0b within %0d cycles",
                                    level, limit));
            end
            step();
            cycles++;
        end
    endtask

    task automatic write_cfg(input cfg_reg_e sel, input logic [WORD_W-1:0] value);
        cfg_reg   = sel;
        cfg_wdata = value;
        cfg_write = 1'b1;
        step();
        cfg_write = 1'b0;
    endtask

    task automatic cpu_read(input logic [CPU_ADDR_W-1:0] address);
        int cycles;
        read_expect.push_back(expected_word(USER_BASE + FLASH_ADDR_W'(4 * address)));
        read_address = address;
        read_en      = 1'b1;
        step();
        read_en = 1'b0;
        cycles  = 0;
        while (read_ready !== 1'b1) begin
            if (cycles == READ_TIMEOUT) begin
                abort_run($sformatf("no read_ready for CPU address %h", address));
            end
            step();
            cycles++;
        end
        // the compare process takes the word at the falling edge
        step();
    endtask

    task automatic record_copy(input logic [FLASH_ADDR_W-1:0] base, input int words,
                               input logic [WORD_W-1:0] dest);
        int index;
        for (int i = 0; i < words; i++) begin
            index              = (int'(dest[RAM_AW-1:0]) + i) % RAM_WORDS;
            ram_model[index]   = expected_word(base + FLASH_ADDR_W'(4 * i));
            ram_written[index] = 1'b1;
        end
    endtask

    task automatic check_ram();
        logic [WORD_W-1:0] data;
        for (int i = 0; i < RAM_WORDS; i++) begin
            if (ram_written[i]) begin
                ram_read_address = RAM_AW'(i);
                ram_read_en      = 1'b1;
                step();
                ram_read_en = 1'b0;
                data        = ram_read_data;
                check_value($sformatf("ram_read_data[%0d]", i), data, ram_model[i]);
            end
        end
    endtask

    // compares every read_ready against the oldest pending CPU read
    always @(negedge clk) begin
        if (read_ready === 1'b1) begin
            if (read_expect.size() == 0) begin
                abort_run("read_ready pulsed with no CPU read pending");
            end else begin
                check_value("read_data", read_data, read_expect.pop_front());
            end
        end
    end

    initial begin
        logic [FLASH_ADDR_W-1:0] load_base;
        logic [FLASH_ADDR_W-1:0] copy_base;
        logic [WORD_W-1:0]       write_base;
        int                      words;

        void'($urandom(32'h38d8_d073));
        reset            = 1'b1;
        read_en          = 1'b0;
        read_address     = '0;
        cfg_write        = 1'b0;
        cfg_reg          = CFG_LOAD_BASE;
        cfg_wdata        = '0;
        ram_read_en      = 1'b0;
        ram_read_address = '0;

        repeat (8) @(posedge clk);
        #1;
        check_value("flash_csn", 32'(flash_csn), 32'd1);
        check_value("flash_sck", 32'(flash_sck), 32'd0);
        check_value("read_ready", 32'(read_ready), 32'd0);
        reset = 1'b0;

        // boot copy started by IPL
        wait_busy(1'b1, 4);
        wait_busy(1'b0, COPY_TIMEOUT);
        record_copy(LOAD_BASE, int'(LOAD_WORDS), WRITE_BASE);
        check_ram();

        // random CPU reads
        repeat (20) cpu_read(CPU_ADDR_W'($urandom()));

        // reprogrammed copy
        load_base  = FLASH_ADDR_W'($urandom());
        words      = 1 + int'($urandom() % 8);
        write_base = $urandom() % RAM_WORDS;
        write_cfg(CFG_LOAD_BASE, WORD_W'(load_base));
        write_cfg(CFG_LOAD_WORDS, WORD_W'(words));
        write_cfg(CFG_WRITE_BASE, write_base);
        write_cfg(CFG_START, '0);
        wait_busy(1'b1, 4);
        wait_busy(1'b0, COPY_TIMEOUT);
        record_copy(load_base, words, write_base);
        check_ram();

        // start and read while a copy runs are both dropped
        copy_base  = FLASH_ADDR_W'($urandom());
        write_base = $urandom() % RAM_WORDS;
        write_cfg(CFG_LOAD_BASE, WORD_W'(copy_base));
        write_cfg(CFG_LOAD_WORDS, 32'd8);
        write_cfg(CFG_WRITE_BASE, write_base);
        write_cfg(CFG_START, '0);
        wait_busy(1'b1, 4);
        repeat (20) step();
        // a new base here would show up if the second start were taken
        load_base = FLASH_ADDR_W'($urandom());
        write_cfg(CFG_LOAD_BASE, WORD_W'(load_base));
        write_cfg(CFG_START, '0);
        read_address = CPU_ADDR_W'($urandom());
        read_en      = 1'b1;
        step();
        read_en = 1'b0;
        // both strobes must have landed inside the running copy
        check_value("dma_busy", 32'(dma_busy), 32'd1);
        wait_busy(1'b0, COPY_TIMEOUT);
        record_copy(copy_base, 8, write_base);
        check_ram();
        cpu_read(CPU_ADDR_W'($urandom()));

        // zero-length copy leaves the RAM alone
        write_cfg(CFG_LOAD_WORDS, 32'd0);
        write_cfg(CFG_START, '0);
        wait_busy(1'b1, 4);
        wait_busy(1'b0, COPY_TIMEOUT);
        check_ram();

        check_value("bad_command", 32'(bad_command), 32'd0);
        repeat (4) step();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
